// ==== filelist.f ====
+incdir+testbench
logic/ram2ePkg.sv
logic/phaseSequencer.sv
logic/sdramSequencer.sv
logic/ramWorksBank.sv
logic/cmdDetector.sv
logic/ram2eTop.sv
testbench/ram2eTb.sv

// ==== logic/cmdDetector.sv ====
`timescale 1ns/1ps

module cmdDetector (
    input  logic                  C14M,
    input  logic                  reset_i,
    input  ram2ePkg::phase_t      phase_i,
    input  logic                  bankSel_i,
    input  logic [7:0]            din_i,
    input  logic                  en80_i,
    output ram2ePkg::cmdStrobes_t strobes_o,
    output logic                  ledEn_o,
    output logic                  led_o
);
    import ram2ePkg::*;

    logic [2:0] seqState;  // Unlock progress, 6 is the command byte
    logic [2:0] toutCount; // Commit phases since the last bank write
    logic       seqMatch;

    // States 6 and 7 take any byte
    assign seqMatch = (seqState >= 3'd6) || (din_i == UnlockSeq[seqState]);

    always_ff @(posedge C14M) begin
        if (reset_i) begin
            seqState  <= '0;
            toutCount <= '0;
            strobes_o <= '0;
            ledEn_o   <= 1'b0;
        end else if (phase_i == PhaseCommit) begin
            if (bankSel_i) begin
                seqState  <= seqMatch ? seqState + 3'd1 : 3'd0;
                toutCount <= '0;
                if (strobes_o.ledSet) begin
                    ledEn_o <= din_i[0];
                end
                if (seqState == 3'd6) begin
                    strobes_o.maskSet <= din_i == CmdMaskSet;
                    strobes_o.ledSet  <= din_i == CmdLedSet;
                    strobes_o.ledGet  <= din_i == CmdLedGet;
                    strobes_o.bankFf  <= din_i == CmdBankFfLed;
                end else begin
                    strobes_o <= '0; // Strobes last one bank write
                end
            end else begin
                toutCount <= toutCount + 3'd1;
                if (toutCount == CmdTimeoutMax) begin
                    seqState <= '0; // Sequence went stale
                end
            end
        end
    end

    assign led_o = !(en80_i && ledEn_o); // Active low

    // Command bytes are distinct, so one strobe at most
    assert property (@(posedge C14M) disable iff (reset_i) $onehot0(strobes_o));

endmodule

// ==== logic/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer #(
    parameter int InitWidth = 16
) (
    input  logic                 C14M,
    input  logic                 reset_i,
    input  logic                 phi1_i,
    output ram2ePkg::phase_t     phase_o,
    output logic [InitWidth-1:0] initCount_o,
    output logic                 ready_o
);
    import ram2ePkg::*;

    logic   phi1Q;     // PHI1 seen on the previous edge
    logic   phi1Rise;
    phase_t phaseNext;

    assign phi1Rise = phi1_i && !phi1Q;

    always_comb begin
        phaseNext = phase_o;
        if (phi1Rise && ready_o) begin
            phaseNext = 4'd1; // Resync to the start of PHI1
        end else if (phase_o != 4'd0 && phase_o != 4'd15) begin
            phaseNext = phase_o + 4'd1;
        end
    end

    always_ff @(posedge C14M) begin
        if (reset_i) begin
            initCount_o <= '0;
            phi1Q       <= 1'b0;
            phase_o     <= '0;
            ready_o     <= 1'b0;
        end else begin
            initCount_o <= initCount_o + 1'b1; // Free running, also paces refresh
            phi1Q       <= phi1_i;
            phase_o     <= phaseNext;
            if (initCount_o == '1) begin
                ready_o <= 1'b1;
            end
        end
    end

    // Bus phases only start once the SDRAM init script has run
    assert property (@(posedge C14M) disable iff (reset_i)
        !ready_o |=> phase_o == 4'd0);

endmodule

// ==== logic/ram2ePkg.sv ====
package ram2ePkg;

    // Bus phase, 0 is init and 1..15 follow the host bus cycle
    typedef logic [3:0] phase_t;

    localparam phase_t PhaseActivate     = 4'd2;
    localparam phase_t PhaseVideoRead    = 4'd3;
    localparam phase_t PhaseRefresh      = 4'd6;
    localparam phase_t PhaseRowLatch     = 4'd7;
    localparam phase_t PhaseMainActivate = 4'd8;
    localparam phase_t PhaseMainRw       = 4'd9;
    localparam phase_t PhaseDataOut      = 4'd11; // Data drive window runs 11..15
    localparam phase_t PhaseCommit       = 4'd12;

    typedef struct packed {
        logic csN;
        logic rasN;
        logic casN;
        logic weN;
    } sdramCmd_t;

    localparam sdramCmd_t CmdNop       = 4'b1111;
    localparam sdramCmd_t CmdActivate  = 4'b0011;
    localparam sdramCmd_t CmdRead      = 4'b0101;
    localparam sdramCmd_t CmdWrite     = 4'b0100;
    localparam sdramCmd_t CmdRefresh   = 4'b0001;
    localparam sdramCmd_t CmdPrecharge = 4'b0010;
    localparam sdramCmd_t CmdModeSet   = 4'b0000;

    typedef struct packed {
        logic        cke;
        sdramCmd_t   cmd;
        logic [1:0]  ba;
        logic [11:0] addr;
        logic        dqml;
        logic        dqmh;
    } sdramBus_t;

    localparam logic [11:0] ModeRegValue = 12'h220; // CL2, burst 1, single write

    typedef logic [7:0] bank_t; // RAMWorks bank

    typedef struct packed {
        logic maskSet;
        logic ledSet;
        logic ledGet;
        logic bankFf;
    } cmdStrobes_t;

    // Index 0 is the first byte of the unlock sequence
    localparam logic [5:0][7:0] UnlockSeq = {8'hAD, 8'hC1, 8'hAA, 8'h55, 8'h00, 8'hFF};

    localparam logic [7:0] CmdMaskSet   = 8'hE0;
    localparam logic [7:0] CmdLedSet    = 8'hE2;
    localparam logic [7:0] CmdLedGet    = 8'hE3;
    localparam logic [7:0] CmdBankFfLed = 8'hF0;

    localparam logic [2:0] CmdTimeoutMax = 3'd7;

endpackage

// ==== logic/ram2eTop.sv ====
`timescale 1ns/1ps

module ram2eTop #(
    parameter int InitWidth = 16
) (
    input  logic                C14M,
    input  logic                reset_i,
    input  logic                phi1_i,
    input  logic                nWe_i,
    input  logic                nWe80_i,
    input  logic                nEn80_i,
    input  logic                nC07X_i,
    input  logic [7:0]          ain_i,
    input  logic [7:0]          din_i,
    input  logic [7:0]          sdramDq_i,
    output logic [7:0]          dout_o,
    output logic                nDoe_o,
    output logic [7:0]          vout_o,
    output logic                nVoe_o,
    output logic                led_o,
    output ram2ePkg::sdramBus_t sdram_o,
    output logic [7:0]          sdramDq_o,
    output logic                sdramDqOe_o
);
    import ram2ePkg::*;

    phase_t               phase;
    logic [InitWidth-1:0] initCount;
    logic                 en80;
    logic [7:0]           rowAddr;
    logic                 bankSel;
    bank_t                bank;
    cmdStrobes_t          strobes;
    logic                 ledEn;

    assign en80   = !nEn80_i;
    assign nVoe_o = phi1_i; // Video bus driven while PHI1 is low

    phaseSequencer #(.InitWidth(InitWidth)) uPhase (
        .C14M        (C14M),
        .reset_i     (reset_i),
        .phi1_i      (phi1_i),
        .phase_o     (phase),
        .initCount_o (initCount),
        .ready_o     ()
    );

    sdramSequencer #(.InitWidth(InitWidth)) uSdram (
        .C14M        (C14M),
        .reset_i     (reset_i),
        .phase_i     (phase),
        .initCount_i (initCount),
        .ain_i       (ain_i),
        .en80_i      (en80),
        .nWe_i       (nWe_i),
        .nWe80_i     (nWe80_i),
        .bank_i      (bank),
        .din_i       (din_i),
        .sdramDq_i   (sdramDq_i),
        .sdram_o     (sdram_o),
        .sdramDq_o   (sdramDq_o),
        .sdramDqOe_o (sdramDqOe_o),
        .dout_o      (dout_o),
        .vout_o      (vout_o),
        .nDoe_o      (nDoe_o),
        .rowAddr_o   (rowAddr)
    );

    ramWorksBank uBank (
        .C14M      (C14M),
        .reset_i   (reset_i),
        .phase_i   (phase),
        .rowAddr_i (rowAddr),
        .nWe_i     (nWe_i),
        .nC07X_i   (nC07X_i),
        .din_i     (din_i),
        .strobes_i (strobes),
        .ledEn_i   (ledEn),
        .bankSel_o (bankSel),
        .bank_o    (bank)
    );

    cmdDetector uCmd (
        .C14M      (C14M),
        .reset_i   (reset_i),
        .phase_i   (phase),
        .bankSel_i (bankSel),
        .din_i     (din_i),
        .en80_i    (en80),
        .strobes_o (strobes),
        .ledEn_o   (ledEn),
        .led_o     (led_o)
    );

endmodule

// ==== logic/ramWorksBank.sv ====
`timescale 1ns/1ps

module ramWorksBank (
    input  logic                  C14M,
    input  logic                  reset_i,
    input  ram2ePkg::phase_t      phase_i,
    input  logic [7:0]            rowAddr_i,
    input  logic                  nWe_i,
    input  logic                  nC07X_i,
    input  logic [7:0]            din_i,
    input  ram2ePkg::cmdStrobes_t strobes_i,
    input  logic                  ledEn_i,
    output logic                  bankSel_o,
    output ram2ePkg::bank_t       bank_o
);
    import ram2ePkg::*;

    bank_t mask;     // Capacity mask, bits 6:0 stored inverted
    bank_t bankData;
    logic  forceFf;

    assign bankData = din_i & {mask[7], ~mask[6:0]};
    assign forceFf  = strobes_i.bankFf || (strobes_i.ledGet && ledEn_i);

    always_ff @(posedge C14M) begin
        if (reset_i) begin
            bankSel_o <= 1'b0;
            bank_o    <= '0;
            mask      <= '0;
        end else begin
            if (phase_i == PhaseMainRw) begin
                // Write to C071/C073 style bank register address
                bankSel_o <= rowAddr_i[0] && !rowAddr_i[3] && !nWe_i && !nC07X_i;
            end
            if (phase_i == PhaseCommit && bankSel_o) begin
                if (forceFf) begin
                    bank_o <= 8'hFF;
                end else begin
                    bank_o <= bankData;
                end
                if (strobes_i.maskSet) begin
                    mask <= {din_i[7], ~din_i[6:0]};
                end
            end
        end
    end

endmodule

// ==== logic/sdramSequencer.sv ====
`timescale 1ns/1ps

module sdramSequencer #(
    parameter int InitWidth = 16
) (
    input  logic                 C14M,
    input  logic                 reset_i,
    input  ram2ePkg::phase_t     phase_i,
    input  logic [InitWidth-1:0] initCount_i,
    input  logic [7:0]           ain_i,
    input  logic                 en80_i,
    input  logic                 nWe_i,
    input  logic                 nWe80_i,
    input  ram2ePkg::bank_t      bank_i,
    input  logic [7:0]           din_i,
    input  logic [7:0]           sdramDq_i,
    output ram2ePkg::sdramBus_t  sdram_o,
    output logic [7:0]           sdramDq_o,
    output logic                 sdramDqOe_o,
    output logic [7:0]           dout_o,
    output logic [7:0]           vout_o,
    output logic                 nDoe_o,
    output logic [7:0]           rowAddr_o
);
    import ram2ePkg::*;

    sdramBus_t  busNext;
    logic [7:0] rowQ;      // Row for the next activate
    logic       doeEn;     // Inside the data drive window
    logic [5:0] initLow;
    logic       initTail;  // Last 64 counts of init
    logic       initCke;   // Last 256 counts of init

    assign initLow  = initCount_i[5:0];
    assign initTail = &(initCount_i | InitWidth'(6'h3F));
    assign initCke  = &(initCount_i | InitWidth'(8'hFF));

    always_comb begin
        busNext.cke  = 1'b1;
        busNext.cmd  = CmdNop;
        busNext.ba   = 2'b00;
        busNext.addr = {4'h0, rowQ};
        busNext.dqml = 1'b1; // Mask both bytes unless reading or writing
        busNext.dqmh = 1'b1;
        case (phase_i)
            4'd0: begin
                busNext.cke  = initCke;
                busNext.addr = ModeRegValue;
                if (initTail && initLow == 6'd0) begin
                    busNext.cmd      = CmdPrecharge;
                    busNext.addr[10] = 1'b1; // All banks
                end else if (initTail && initLow == 6'd40) begin
                    busNext.cmd = CmdModeSet;
                end else if (initTail && initLow[4] && !initLow[0]) begin
                    busNext.cmd = CmdRefresh; // 8x at 16..31 and 48..63
                end
            end
            PhaseActivate: begin
                busNext.cmd = CmdActivate; // Video row, bank 0
            end
            PhaseVideoRead: begin
                busNext.cmd  = CmdRead;
                busNext.addr = {4'b0100, ain_i}; // Auto precharge
                busNext.dqml = 1'b0;
            end
            PhaseRefresh: begin
                if (initCount_i[5:4] == 2'b00) begin
                    busNext.cmd = CmdRefresh;
                end
            end
            PhaseMainActivate: begin
                busNext.cke     = en80_i;
                busNext.cmd     = CmdActivate;
                busNext.cmd.csN = !en80_i;
                busNext.ba      = bank_i[5:4];
                busNext.addr    = {bank_i[3:0], rowQ};
            end
            PhaseMainRw: begin
                busNext.cke     = en80_i;
                busNext.cmd     = nWe80_i ? CmdRead : CmdWrite;
                busNext.cmd.csN = !en80_i;
                busNext.ba      = bank_i[5:4];
                busNext.addr    = {3'b010, bank_i[7], ain_i};
                busNext.dqml    = bank_i[6];  // Upper half of the bank space is the high byte
                busNext.dqmh    = !bank_i[6];
            end
            4'd10: begin
                busNext.cke = en80_i;
            end
            default: begin
                if (phase_i >= PhaseDataOut) begin
                    busNext.cke = 1'b0; // Clock stopped while the host samples data
                end
            end
        endcase
    end

    always_ff @(posedge C14M) begin
        if (reset_i) begin
            sdram_o.cke  <= 1'b0;
            sdram_o.cmd  <= CmdNop;
            sdram_o.ba   <= 2'b00;
            sdram_o.addr <= 12'h000;
            sdram_o.dqml <= 1'b1;
            sdram_o.dqmh <= 1'b1;
            doeEn        <= 1'b0;
        end else begin
            sdram_o <= busNext;
            doeEn   <= phase_i >= PhaseDataOut;
        end
    end

    // Main row at phase 7, next video row late in the cycle
    always_ff @(posedge C14M) begin
        if (phase_i == PhaseRowLatch || phase_i >= 4'd14) begin
            rowQ <= ain_i;
        end
    end

    // Read data settles by the falling edge
    always_ff @(negedge C14M) begin
        if (phase_i == PhaseRefresh) begin
            vout_o <= sdramDq_i;
        end
        if (phase_i == PhaseCommit) begin
            dout_o <= sdramDq_i;
        end
    end

    assign rowAddr_o   = rowQ;
    assign nDoe_o      = !(en80_i && nWe_i && doeEn);
    assign sdramDqOe_o = en80_i && !nWe80_i;
    assign sdramDq_o   = din_i;

    // SDRAM clock must be stopped through the data window
    assert property (@(posedge C14M) disable iff (reset_i)
        phase_i >= PhaseDataOut |=> !sdram_o.cke);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module ram2eTb -o simRam2e

# The simulator exits non-zero on failure, the log decides the result
./obj_dir/simRam2e > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1

// ==== testbench/ram2eTbTasks.svh ====
`ifndef RAM2E_TB_TASKS_SVH
`define RAM2E_TB_TASKS_SVH

// Galois LFSR, taps for a 16-bit maximal sequence
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// One step per bit taken
function logic [7:0] randomByte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
        b[i]      = lfsrState[0];
        lfsrState = lfsrStep(lfsrState);
    end
    return b;
endfunction

function automatic string cmdName(input sdramCmd_t c);
    case (c)
        CmdNop:       return "NOP";
        CmdActivate:  return "ACTIVATE";
        CmdRead:      return "READ";
        CmdWrite:     return "WRITE";
        CmdRefresh:   return "REFRESH";
        CmdPrecharge: return "PRECHARGE";
        CmdModeSet:   return "MODESET";
        default:      return "UNKNOWN";
    endcase
endfunction

task automatic checkCmd(input string name, input sdramCmd_t exp, input sdramCmd_t act);
    if (exp !== act) begin
        failRun($sformatf("Error %s: expected %s, actual %s (%b)",
                          name, cmdName(exp), cmdName(act), act));
    end
endtask

task automatic checkBus(input string name, input sdramBus_t exp, input sdramBus_t act);
    if (exp !== act) begin
        failRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic checkAddr(input string name, input logic [11:0] exp, input logic [11:0] act);
    if (exp !== act) begin
        failRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic checkByte(input string name, input bank_t exp, input bank_t act);
    if (exp !== act) begin
        failRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        failRun($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    end
endtask

`endif

// ==== testbench/ram2eTb.sv ====
`timescale 1ns/1ps

module ram2eTb;
    import ram2ePkg::*;

    localparam int InitBits = 10;

    typedef struct packed {
        logic       en80;
        logic       nWe80;
        logic       nWe;
        logic       nC07X;
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] din;
        bank_t      bank;  // Bank in effect during this cycle
        logic       led;   // LED pin after the cycle
    } testRec_t;

    logic       C14M;
    logic       reset;
    logic       phi1;
    logic       nWe;
    logic       nWe80;
    logic       nEn80;
    logic       nC07X;
    logic [7:0] ain;
    logic [7:0] din;
    logic [7:0] sdramDqIn;
    logic [7:0] dout;
    logic       nDoe;
    logic [7:0] vout;
    logic       nVoe;
    logic       led;
    sdramBus_t  sdramBus;
    logic [7:0] sdramDqOut;
    logic       sdramDqOe;

    logic [15:0] lfsrState = 16'd48;
    string       names[$];
    int          repsQ[$];
    testRec_t    recs[$];
    int          cycleCount = 0;
    int          cycleLimit = 0;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    `include "ram2eTbTasks.svh"

    ram2eTop #(.InitWidth(InitBits)) dut (
        .C14M        (C14M),
        .reset_i     (reset),
        .phi1_i      (phi1),
        .nWe_i       (nWe),
        .nWe80_i     (nWe80),
        .nEn80_i     (nEn80),
        .nC07X_i     (nC07X),
        .ain_i       (ain),
        .din_i       (din),
        .sdramDq_i   (sdramDqIn),
        .dout_o      (dout),
        .nDoe_o      (nDoe),
        .vout_o      (vout),
        .nVoe_o      (nVoe),
        .led_o       (led),
        .sdram_o     (sdramBus),
        .sdramDq_o   (sdramDqOut),
        .sdramDqOe_o (sdramDqOe)
    );

    initial begin
        C14M = 1'b0;
        forever #10 C14M = ~C14M;
    end

    always @(posedge C14M) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            failRun("Timeout: the run went past its cycle limit");
        end
    end

    task automatic readTests();
        int    fd;
        int    code;
        int    n;
        int    f[10];
        string line;
        string nm;
        fd = $fopen("testbench/ram2e_testdata.txt", "r");
        if (fd == 0) begin
            failRun("Could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h", nm, f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n != 11) begin
                failRun($sformatf("Malformed test data line: %s", line));
            end
            names.push_back(nm);
            repsQ.push_back(f[0]);
            recs.push_back({f[1][0], f[2][0], f[3][0], f[4][0], f[5][7:0], f[6][7:0],
                            f[7][7:0], f[8][7:0], f[9][0]});
        end
        $fclose(fd);
    endtask

    // Power-up script, one sample per init count
    task automatic checkInit();
        sdramCmd_t   cmdQ[$];
        logic [11:0] addrQ[$];
        int          ckeCount;
        sdramCmd_t   expCmd;
        ckeCount = 0;
        repeat (1 << InitBits) begin
            @(negedge C14M);
            if (sdramBus.cke) ckeCount++;
            if (sdramBus.cmd != CmdNop) begin
                cmdQ.push_back(sdramBus.cmd);
                addrQ.push_back(sdramBus.addr);
            end
        end
        if (cmdQ.size() != 18) begin
            failRun($sformatf("Power-up gave %0d commands instead of 18", cmdQ.size()));
        end
        if (ckeCount != 256 || !sdramBus.cke) begin
            failRun($sformatf("CKE was high %0d cycles during init, not the last 256",
                              ckeCount));
        end
        for (int i = 0; i < 18; i++) begin
            if (i == 0) expCmd = CmdPrecharge;
            else if (i == 9) expCmd = CmdModeSet;
            else expCmd = CmdRefresh;
            checkCmd($sformatf("init command %0d", i), expCmd, cmdQ[i]);
        end
        checkBit("init precharge all", 1'b1, addrQ[0][10]);
        checkAddr("init mode word", 12'h220, addrQ[9]); // CL2, burst 1, single write
    endtask

    // One 14-cycle host bus cycle, PHI1 high for the first 7
    task automatic runCycle(input int idx);
        testRec_t  r;
        string     nm;
        bank_t     expV;
        bank_t     expD;
        sdramBus_t expBus;
        logic [7:0] vcol;
        r    = recs[idx];
        nm   = names[idx];
        vcol = r.col ^ 8'hFF;
        expV = '0;
        expD = '0;
        for (int k = 0; k < 14; k++) begin
            @(negedge C14M);
            case (k)
                0: begin
                    phi1  = 1'b1;
                    nEn80 = !r.en80;
                    nWe80 = r.nWe80;
                    nWe   = r.nWe;
                    nC07X = r.nC07X;
                    din   = r.din;
                end
                3: ain = vcol;
                4: begin
                    expBus = '{cke: 1'b1, cmd: CmdRead, ba: 2'b00, addr: {4'b0100, vcol},
                               dqml: 1'b0, dqmh: 1'b1};
                    checkBus({nm, " video read"}, expBus, sdramBus);
                    checkBit({nm, " nVOE"}, 1'b1, nVoe);
                    checkBit({nm, " nDOE idle"}, 1'b1, nDoe); // Outside the data window
                end
                5: begin
                    expV      = randomByte();
                    sdramDqIn = expV;
                end
                7: begin
                    phi1 = 1'b0;
                    ain  = r.row;
                    checkByte({nm, " Vout"}, expV, vout);
                end
                9: ain = r.col;
                10: begin
                    if (r.en80) begin
                        expBus = '{cke: 1'b1, cmd: r.nWe80 ? CmdRead : CmdWrite,
                                   ba: r.bank[5:4], addr: {3'b010, r.bank[7], r.col},
                                   dqml: r.bank[6], dqmh: !r.bank[6]};
                        checkBus({nm, " main access"}, expBus, sdramBus);
                    end else begin
                        checkBit({nm, " CS high"}, 1'b1, sdramBus.cmd.csN);
                    end
                    checkBit({nm, " DQ enable"}, r.en80 && !r.nWe80, sdramDqOe);
                    if (r.en80 && !r.nWe80) begin
                        checkByte({nm, " DQ data"}, r.din, sdramDqOut);
                    end
                    checkBit({nm, " nVOE low"}, 1'b0, nVoe); // PHI1 low half
                end
                11: begin
                    expD      = randomByte();
                    sdramDqIn = expD;
                end
                12: checkBit({nm, " nDOE"}, !(r.en80 && r.nWe), nDoe);
                13: begin
                    checkByte({nm, " Dout"}, expD, dout);
                    checkBit({nm, " LED"}, r.led, led);
                end
                default: ;
            endcase
        end
    endtask

    initial begin
        int total;
        reset     = 1'b1;
        phi1      = 1'b0;
        nWe       = 1'b1;
        nWe80     = 1'b1;
        nEn80     = 1'b1;
        nC07X     = 1'b1;
        ain       = 8'h00;
        din       = 8'h00;
        sdramDqIn = 8'h00;
        readTests();
        total = 0;
        foreach (repsQ[i]) total += repsQ[i];
        cycleLimit = 4 + (1 << InitBits) + 14 * total + 100;
        repeat (4) @(posedge C14M);
        @(negedge C14M);
        reset = 1'b0;
        checkInit();
        foreach (recs[i]) begin
            repeat (repsQ[i]) runCycle(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== testbench/ram2e_testdata.txt ====
# name reps en80 nWe80 nWe nC07X row col din expBank expLed (hex except reps)
# expBank is the bank during the cycle, expLed the LED pin after it
read0   1 1 1 1 1 12 34 00 00 1
noEn    1 0 1 1 1 12 34 00 00 1
bankWr  1 1 0 0 0 73 71 93 00 1
bankRd  1 1 1 1 1 12 34 00 13 1
mUnl0   1 1 0 0 0 73 71 FF 13 1
mUnl1   1 1 0 0 0 73 71 00 7F 1
mUnl2   1 1 0 0 0 73 71 55 00 1
mUnl3   1 1 0 0 0 73 71 AA 55 1
mUnl4   1 1 0 0 0 73 71 C1 2A 1
mUnl5   1 1 0 0 0 73 71 AD 41 1
mCmd    1 1 0 0 0 73 71 E0 2D 1
mData   1 1 0 0 0 73 71 0F 60 1
mWr     1 1 0 0 0 73 71 35 0F 1
mRd     1 1 1 1 1 12 34 00 05 1
bUnl0   1 1 0 0 0 73 71 FF 05 1
bUnl1   1 1 0 0 0 73 71 00 0F 1
bUnl2   1 1 0 0 0 73 71 55 00 1
bBad    1 1 0 0 0 73 71 AB 05 1
bUnl4   1 1 0 0 0 73 71 C1 0B 1
bUnl5   1 1 0 0 0 73 71 AD 01 1
bCmd    1 1 0 0 0 73 71 E2 0D 1
bData   1 1 0 0 0 73 71 01 02 1
tUnl0   1 1 0 0 0 73 71 FF 01 1
tUnl1   1 1 0 0 0 73 71 00 0F 1
tUnl2   1 1 0 0 0 73 71 55 00 1
tUnl3   1 1 0 0 0 73 71 AA 05 1
tIdle   8 1 1 1 1 12 34 00 0A 1
tUnl4   1 1 0 0 0 73 71 C1 0A 1
tUnl5   1 1 0 0 0 73 71 AD 01 1
tCmd    1 1 0 0 0 73 71 E2 0D 1
tData   1 1 0 0 0 73 71 01 02 1
lUnl0   1 1 0 0 0 73 71 FF 01 1
lUnl1   1 1 0 0 0 73 71 00 0F 1
lUnl2   1 1 0 0 0 73 71 55 00 1
lUnl3   1 1 0 0 0 73 71 AA 05 1
lUnl4   1 1 0 0 0 73 71 C1 0A 1
lUnl5   1 1 0 0 0 73 71 AD 01 1
lCmd    1 1 0 0 0 73 71 E2 0D 1
lData   1 1 0 0 0 73 71 01 02 0
gUnl0   1 1 0 0 0 73 71 FF 01 0
gUnl1   1 1 0 0 0 73 71 00 0F 0
gUnl2   1 1 0 0 0 73 71 55 00 0
gUnl3   1 1 0 0 0 73 71 AA 05 0
gUnl4   1 1 0 0 0 73 71 C1 0A 0
gUnl5   1 1 0 0 0 73 71 AD 01 0
gCmd    1 1 0 0 0 73 71 E3 0D 0
gData   1 1 0 0 0 73 71 27 03 0
gRd     1 1 1 1 1 12 34 00 FF 0
gNoEn   1 0 1 1 1 12 34 00 FF 1
